// File: Makefile
VERILATOR ?= verilator
TOP       ?= fdct_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -Fxq "$(PASS_MSG)" $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fdct_clk_gen.sv
module fdct_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1; // Released away from the edge
    end

endmodule

// File: bench/fdct_properties.sv
module fdct_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 pready_i,
    input logic                 start_i,
    input logic                 busy_i,
    input logic                 done_i,
    input fdct_pkg::seq_state_e state_i
);

    int fail_count = 0; // Failed assertions so far

    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready_i)
        else begin
            fail_count++;
            $error("pready dropped low");
        end

    // Start pulse only as the sequencer leaves IDLE
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (state_i == fdct_pkg::ROW) && ($past(state_i) == fdct_pkg::IDLE))
        else begin
            fail_count++;
            $error("start pulse without a move from IDLE to ROW");
        end

    a_done_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start_i, 3) |-> $rose(done_i))
        else begin
            fail_count++;
            $error("done did not rise 3 cycles after start");
        end

    a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_i) |-> $past(start_i, 3))
        else begin
            fail_count++;
            $error("done rose without a start 3 cycles earlier");
        end

    a_busy_done: assert property (@(posedge clk) disable iff (!rst_n) !(busy_i && done_i))
        else begin
            fail_count++;
            $error("busy and done high together");
        end

endmodule

bind fdct_apb_regs fdct_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .pready_i   (pready_o),
    .start_i    (start_o),
    .busy_i     (busy),
    .done_i     (done_q),
    .state_i    (state_q)
);

// File: bench/fdct_tb.sv
`include "fdct_settings.svh"

module fdct_tb;

    localparam int BLK         = `FDCT_BLK;
    localparam int NPIX        = BLK * BLK;
    localparam int AW          = `FDCT_APB_AW;
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_BLOCKS  = NUM_RANDOM + 3 + 2 + 2; // Edge, status and error jobs
    localparam int TIMEOUT_CYC = NUM_BLOCKS * 60 + 500;
    localparam int MAX_POLLS   = 16;

    typedef logic [AW-1:0] addr_t;

    logic        clk;
    logic        rst_n;
    logic        psel, penable, pwrite;
    addr_t       paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    int              seed = 84549;
    int              errors, checks, tests, failed_tests;
    int              src_pix [NPIX];
    int              ref_pix [NPIX];
    fdct_pkg::coef_t exp_coef [NPIX];

    fdct_clk_gen u_clk (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    fdct_apb_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .paddr_i  (paddr),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pready_o (pready),
        .pslverr_o(pslverr)
    );

    // ----------------------------------------
    // Bus access, entered 1 unit after an edge
    // ----------------------------------------
    task automatic transfer(input logic wr, input addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 rdata = prdata; // Mid access phase
        err = pslverr;
        check_word("pready", 32'h1, 32'(pready));
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    function automatic addr_t word_addr(input addr_t base, input int idx);
        return base + addr_t'(4 * idx);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic check_coef(input string name, input fdct_pkg::coef_t exp,
                              input fdct_pkg::coef_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED, %0d errors", name, errors - errs_before);
        end
    endtask

    // ----------------------------------------
    // Reference model of the VP8 transform
    // ----------------------------------------
    task automatic compute_model();
        int t [NPIX];
        int d [BLK];
        int a0, a1, a2, a3, b0, b1, b2, b3;
        for (int r = 0; r < BLK; r++) begin
            for (int k = 0; k < BLK; k++) begin
                d[k] = src_pix[BLK*r+k] - ref_pix[BLK*r+k];
            end
            a0 = d[0] + d[3];
            a1 = d[1] + d[2];
            a2 = d[1] - d[2];
            a3 = d[0] - d[3];
            t[BLK*r+0] = (a0 + a1) * 8;
            t[BLK*r+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
            t[BLK*r+2] = (a0 - a1) * 8;
            t[BLK*r+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
        end
        for (int c = 0; c < BLK; c++) begin
            b0 = t[c] + t[BLK*3+c];
            b1 = t[BLK+c] + t[BLK*2+c];
            b2 = t[BLK+c] - t[BLK*2+c];
            b3 = t[c] - t[BLK*3+c];
            exp_coef[c]       = fdct_pkg::coef_t'((b0 + b1 + 7) >>> 4);
            exp_coef[BLK+c]   = fdct_pkg::coef_t'(((b2 * 2217 + b3 * 5352 + 12000) >>> 16)
                                                  + ((b3 != 0) ? 1 : 0));
            exp_coef[BLK*2+c] = fdct_pkg::coef_t'((b0 - b1 + 7) >>> 4);
            exp_coef[BLK*3+c] = fdct_pkg::coef_t'((b3 * 2217 - b2 * 5352 + 51000) >>> 16);
        end
    endtask

    task automatic fill_block(input int src_val, input int ref_val, input logic rnd);
        for (int i = 0; i < NPIX; i++) begin
            src_pix[i] = rnd ? ($random(seed) & 255) : src_val;
            ref_pix[i] = rnd ? ($random(seed) & 255) : ref_val;
        end
        compute_model();
    endtask

    task automatic load_block();
        logic [31:0] ws, wr, rd;
        logic        err;
        for (int r = 0; r < BLK; r++) begin
            for (int k = 0; k < BLK; k++) begin
                ws[8*k +: 8] = 8'(src_pix[BLK*r+k]); // Pixel k in byte k
                wr[8*k +: 8] = 8'(ref_pix[BLK*r+k]);
            end
            transfer(1'b1, word_addr(`FDCT_SRC_BASE, r), ws, rd, err);
            check_word("pslverr", 32'h0, 32'(err));
            transfer(1'b1, word_addr(`FDCT_REF_BASE, r), wr, rd, err);
            check_word("pslverr", 32'h0, 32'(err));
        end
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        rd    = '0;
        while (!rd[1] && polls < MAX_POLLS) begin
            transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
            polls++;
        end
        if (!rd[1]) begin
            errors++;
            $display("Done bit was not set after %0d status reads at time %0t", polls, $time);
        end
    endtask

    task automatic compare_coefs();
        logic [31:0] rd;
        logic        err;
        for (int n = 0; n < NPIX; n++) begin
            transfer(1'b0, word_addr(`FDCT_COEF_BASE, n), 32'h0, rd, err);
            check_coef($sformatf("coef[%0d]", n), exp_coef[n], fdct_pkg::coef_t'(rd));
            check_word($sformatf("prdata coef[%0d]", n), 32'(exp_coef[n]), rd); // Sign extension
        end
    endtask

    task automatic run_job();
        logic [31:0] rd;
        logic        err;
        load_block();
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        check_word("pslverr", 32'h0, 32'(err));
        wait_done();
        compare_coefs();
    endtask

    initial begin
        logic [31:0] rd, old;
        logic [31:0] words [2*BLK];
        logic        err;
        int          e0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        e0 = errors;
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", 32'h0, rd);
        for (int n = 0; n < NPIX; n++) begin
            transfer(1'b0, word_addr(`FDCT_COEF_BASE, n), 32'h0, rd, err);
            check_word($sformatf("coef[%0d]", n), 32'h0, rd);
        end
        report_test("reset values", e0);

        // SRC and REF words are contiguous
        e0 = errors;
        for (int i = 0; i < 2 * BLK; i++) begin
            words[i] = $random(seed);
            transfer(1'b1, word_addr(`FDCT_SRC_BASE, i), words[i], rd, err);
            check_word("pslverr", 32'h0, 32'(err));
        end
        for (int i = 0; i < 2 * BLK; i++) begin
            transfer(1'b0, word_addr(`FDCT_SRC_BASE, i), 32'h0, rd, err);
            check_word($sformatf("pixel word %0d", i), words[i], rd);
        end
        report_test("buffer readback", e0);

        e0 = errors;
        for (int b = 0; b < NUM_RANDOM; b++) begin
            fill_block(0, 0, 1'b1);
            run_job();
        end
        report_test("random blocks", e0);

        e0 = errors;
        fill_block(255, 0, 1'b0);
        run_job();
        fill_block(0, 255, 1'b0);
        run_job();
        fill_block(0, 0, 1'b1);
        ref_pix = src_pix;      // Zero residual
        compute_model();
        run_job();
        report_test("edge blocks", e0);

        e0 = errors;
        fill_block(0, 0, 1'b1);
        load_block();
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", 32'h1, rd); // Busy, not yet done
        @(posedge clk);
        #1;
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", 32'h2, rd);
        repeat (5) @(posedge clk);
        #1;
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", 32'h2, rd); // Sticky
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", 32'h1, rd);
        wait_done();
        report_test("status timing", e0);

        e0 = errors;
        transfer(1'b0, 8'h30, 32'h0, rd, err);
        check_word("pslverr", 32'h1, 32'(err));
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, old, err);
        transfer(1'b1, `FDCT_STATUS_ADDR, 32'hffff_ffff, rd, err);
        check_word("pslverr", 32'h1, 32'(err));
        transfer(1'b0, `FDCT_STATUS_ADDR, 32'h0, rd, err);
        check_word("status", old, rd);
        transfer(1'b0, `FDCT_COEF_BASE, 32'h0, old, err);
        transfer(1'b1, `FDCT_COEF_BASE, 32'h5a5, rd, err);
        check_word("pslverr", 32'h1, 32'(err));
        transfer(1'b0, `FDCT_COEF_BASE, 32'h0, rd, err);
        check_word("coef[0]", old, rd);
        fill_block(0, 0, 1'b1);
        load_block();
        transfer(1'b0, `FDCT_SRC_BASE, 32'h0, old, err);
        // A job lasts three cycles, so one access per job lands while busy
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        transfer(1'b1, `FDCT_SRC_BASE, ~old, rd, err);
        check_word("pslverr", 32'h1, 32'(err));
        wait_done();
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        transfer(1'b1, `FDCT_CTRL_ADDR, 32'h1, rd, err);
        check_word("pslverr", 32'h1, 32'(err));
        wait_done();
        transfer(1'b0, `FDCT_SRC_BASE, 32'h0, rd, err);
        check_word("src word 0", old, rd);
        compare_coefs();
        report_test("bus errors", e0);

        errors += uut.u_regs.u_props.fail_count;
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

// File: design/fdct_apb_regs.sv
`include "fdct_settings.svh"

module fdct_apb_regs (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                psel_i,
    input  logic                                                penable_i,
    input  logic                                                pwrite_i,
    input  logic [`FDCT_APB_AW-1:0]                             paddr_i,
    input  logic [31:0]                                         pwdata_i,
    output logic [31:0]                                         prdata_o,
    output logic                                                pready_o,
    output logic                                                pslverr_o,
    output fdct_pkg::pixel_t [(`FDCT_BLK*`FDCT_BLK)-1:0]        src_blk_o,
    output fdct_pkg::pixel_t [(`FDCT_BLK*`FDCT_BLK)-1:0]        ref_blk_o,
    output logic                                                start_o,
    input  fdct_pkg::coef_t  [(`FDCT_BLK*`FDCT_BLK)-1:0]        coef_blk_i,
    input  logic                                                col_valid_i
);

    localparam int NPIX       = `FDCT_BLK * `FDCT_BLK;
    localparam int BUF_BYTES  = `FDCT_BLK * 4;  // One word per pixel row
    localparam int COEF_BYTES = NPIX * 4;
    localparam int WIDX_W     = $clog2(`FDCT_BLK);
    localparam int CIDX_W     = $clog2(NPIX);

    fdct_pkg::reg_sel_e   reg_sel;
    fdct_pkg::seq_state_e state_q;
    fdct_pkg::seq_state_e state_d;

    logic [`FDCT_APB_AW-1:0] src_off, ref_off, coef_off;
    logic [WIDX_W-1:0]       word_idx;
    logic [CIDX_W-1:0]       coef_idx;
    logic                    access, err, wr_ok, start_acc;
    logic                    busy, done_q;
    logic [31:0]             rd_data;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign src_off  = paddr_i - `FDCT_SRC_BASE; // Wraps below base, so one compare
    assign ref_off  = paddr_i - `FDCT_REF_BASE;
    assign coef_off = paddr_i - `FDCT_COEF_BASE;

    always_comb begin
        reg_sel = fdct_pkg::NONE;
        if (paddr_i[1:0] == 2'b00) begin // Word accesses only
            if (src_off < BUF_BYTES) begin
                reg_sel = fdct_pkg::SRC;
            end else if (ref_off < BUF_BYTES) begin
                reg_sel = fdct_pkg::REF;
            end else if (paddr_i == `FDCT_CTRL_ADDR) begin
                reg_sel = fdct_pkg::CTRL;
            end else if (paddr_i == `FDCT_STATUS_ADDR) begin
                reg_sel = fdct_pkg::STATUS;
            end else if (coef_off < COEF_BYTES) begin
                reg_sel = fdct_pkg::COEF;
            end
        end
    end

    assign word_idx = (reg_sel == fdct_pkg::REF) ? ref_off[WIDX_W+1:2] : src_off[WIDX_W+1:2];
    assign coef_idx = coef_off[CIDX_W+1:2];

    // Error and write qualification
    assign access = psel_i && penable_i;
    assign err    = (reg_sel == fdct_pkg::NONE)
                 || (pwrite_i && (reg_sel == fdct_pkg::STATUS || reg_sel == fdct_pkg::COEF))
                 || (pwrite_i && busy);                 // Buffers locked during a job
    assign wr_ok     = access && pwrite_i && !err;
    assign start_acc = wr_ok && (reg_sel == fdct_pkg::CTRL) && pwdata_i[0];

    assign pready_o  = 1'b1; // Zero wait states
    assign pslverr_o = access && err;

    // ----------------------------------------
    // Pixel buffers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_ok && reg_sel == fdct_pkg::SRC) begin
            src_blk_o[`FDCT_BLK*word_idx +: `FDCT_BLK] <= pwdata_i; // Pixel k in byte k
        end
        if (wr_ok && reg_sel == fdct_pkg::REF) begin
            ref_blk_o[`FDCT_BLK*word_idx +: `FDCT_BLK] <= pwdata_i;
        end
    end

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            fdct_pkg::IDLE: if (start_acc) state_d = fdct_pkg::ROW;
            fdct_pkg::ROW:  state_d = fdct_pkg::COL;
            fdct_pkg::COL:  state_d = fdct_pkg::DONE;
            fdct_pkg::DONE: if (col_valid_i) state_d = fdct_pkg::IDLE;
            default:        state_d = fdct_pkg::IDLE;
        endcase
    end

    assign busy = (state_q != fdct_pkg::IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fdct_pkg::IDLE;
            start_o <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            start_o <= start_acc; // Single-cycle pulse
            if (start_acc) begin
                done_q <= 1'b0;
            end else if (state_q == fdct_pkg::DONE && col_valid_i) begin
                done_q <= 1'b1;   // Sticky until next start
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            fdct_pkg::SRC:    rd_data = src_blk_o[`FDCT_BLK*word_idx +: `FDCT_BLK];
            fdct_pkg::REF:    rd_data = ref_blk_o[`FDCT_BLK*word_idx +: `FDCT_BLK];
            fdct_pkg::STATUS: rd_data = {30'b0, done_q, busy};
            fdct_pkg::COEF: begin
                rd_data = {{(32-`FDCT_COEF_W){coef_blk_i[coef_idx][`FDCT_COEF_W-1]}},
                           coef_blk_i[coef_idx]};
            end
            default:          rd_data = '0; // CTRL reads as zero
        endcase
    end

    assign prdata_o = rd_data;

endmodule

// File: design/fdct_apb_top.sv
`include "fdct_settings.svh"

module fdct_apb_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`FDCT_APB_AW-1:0] paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);

    fdct_pkg::pixel_t [(`FDCT_BLK*`FDCT_BLK)-1:0] src_blk, ref_blk;
    fdct_pkg::tmp_t   [(`FDCT_BLK*`FDCT_BLK)-1:0] row_tmp;
    fdct_pkg::coef_t  [(`FDCT_BLK*`FDCT_BLK)-1:0] coef_blk;
    logic                                          start, row_valid, col_valid;

    fdct_apb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .src_blk_o  (src_blk),
        .ref_blk_o  (ref_blk),
        .start_o    (start),
        .coef_blk_i (coef_blk),
        .col_valid_i(col_valid)
    );

    // Two registered transform passes
    fdct_row_pass u_row (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .src_blk_i  (src_blk),
        .ref_blk_i  (ref_blk),
        .row_tmp_o  (row_tmp),
        .row_valid_o(row_valid)
    );

    fdct_col_pass u_col (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid_i(row_valid),
        .row_tmp_i  (row_tmp),
        .coef_blk_o (coef_blk),
        .col_valid_o(col_valid)
    );

endmodule

// File: design/fdct_col_pass.sv
`include "fdct_settings.svh"

module fdct_col_pass (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                row_valid_i,
    input  fdct_pkg::tmp_t   [(`FDCT_BLK*`FDCT_BLK)-1:0]        row_tmp_i,
    output fdct_pkg::coef_t  [(`FDCT_BLK*`FDCT_BLK)-1:0]        coef_blk_o,
    output logic                                                col_valid_o
);

    fdct_pkg::coef_t [(`FDCT_BLK*`FDCT_BLK)-1:0] coef_nxt;

    // ----------------------------------------
    // Vertical butterfly, one per column
    // ----------------------------------------
    genvar c;
    generate
        for (c = 0; c < `FDCT_BLK; c++) begin : g_col
            logic signed [`FDCT_TMP_W:0] b0, b1, b2, b3;
            logic signed [31:0]          s0, s2;
            logic signed [31:0]          p1, p3;
            logic signed [31:0]          q1;

            assign b0 = row_tmp_i[c] + row_tmp_i[`FDCT_BLK*3+c];
            assign b1 = row_tmp_i[`FDCT_BLK+c] + row_tmp_i[`FDCT_BLK*2+c];
            assign b2 = row_tmp_i[`FDCT_BLK+c] - row_tmp_i[`FDCT_BLK*2+c];
            assign b3 = row_tmp_i[c] - row_tmp_i[`FDCT_BLK*3+c];

            assign s0 = (b0 + b1 + 7) >>> 4; // DC and middle AC
            assign s2 = (b0 - b1 + 7) >>> 4;

            assign p1 = b2 * 2217 + b3 * 5352 + 12000;
            assign p3 = (b3 * 2217 - b2 * 5352 + 51000) >>> 16;

            // VP8 bias applied after the shift
            assign q1 = (p1 >>> 16) + ((b3 != 0) ? 32'sd1 : 32'sd0);

            assign coef_nxt[c]              = fdct_pkg::coef_t'(s0);
            assign coef_nxt[`FDCT_BLK+c]    = fdct_pkg::coef_t'(q1);
            assign coef_nxt[`FDCT_BLK*2+c]  = fdct_pkg::coef_t'(s2);
            assign coef_nxt[`FDCT_BLK*3+c]  = fdct_pkg::coef_t'(p3);
        end
    endgenerate

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_blk_o  <= '0;
            col_valid_o <= 1'b0;
        end else begin
            col_valid_o <= row_valid_i;
            if (row_valid_i) begin
                coef_blk_o <= coef_nxt; // Readable until the next job lands
            end
        end
    end

endmodule

// File: design/fdct_pkg.sv
`include "fdct_settings.svh"

package fdct_pkg;

    // Datapath element types
    typedef logic        [`FDCT_PIX_W-1:0]  pixel_t;
    typedef logic signed [`FDCT_TMP_W-1:0]  tmp_t;  // After horizontal pass
    typedef logic signed [`FDCT_COEF_W-1:0] coef_t;

    // Register class of the current APB address
    typedef enum logic [2:0] {
        SRC,
        REF,
        CTRL,
        STATUS,
        COEF,
        NONE
    } reg_sel_e;

    // Job sequencer
    typedef enum logic [1:0] {
        IDLE,
        ROW,  // Row registers loading
        COL,  // Column registers loading
        DONE  // Coefficients land
    } seq_state_e;

endpackage

// File: design/fdct_row_pass.sv
`include "fdct_settings.svh"

module fdct_row_pass (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                start_i,
    input  fdct_pkg::pixel_t [(`FDCT_BLK*`FDCT_BLK)-1:0]        src_blk_i,
    input  fdct_pkg::pixel_t [(`FDCT_BLK*`FDCT_BLK)-1:0]        ref_blk_i,
    output fdct_pkg::tmp_t   [(`FDCT_BLK*`FDCT_BLK)-1:0]        row_tmp_o,
    output logic                                                row_valid_o
);

    fdct_pkg::tmp_t [(`FDCT_BLK*`FDCT_BLK)-1:0] tmp_nxt;

    // ----------------------------------------
    // Residual and horizontal butterfly
    // ----------------------------------------
    genvar r;
    generate
        for (r = 0; r < `FDCT_BLK; r++) begin : g_row
            logic signed [`FDCT_PIX_W:0]   d0, d1, d2, d3; // One extra bit for the sign
            logic signed [`FDCT_PIX_W+1:0] a0, a1, a2, a3;
            logic signed [23:0]            p1, p3;         // Rotation products

            assign d0 = $signed({1'b0, src_blk_i[`FDCT_BLK*r+0]})
                      - $signed({1'b0, ref_blk_i[`FDCT_BLK*r+0]});
            assign d1 = $signed({1'b0, src_blk_i[`FDCT_BLK*r+1]})
                      - $signed({1'b0, ref_blk_i[`FDCT_BLK*r+1]});
            assign d2 = $signed({1'b0, src_blk_i[`FDCT_BLK*r+2]})
                      - $signed({1'b0, ref_blk_i[`FDCT_BLK*r+2]});
            assign d3 = $signed({1'b0, src_blk_i[`FDCT_BLK*r+3]})
                      - $signed({1'b0, ref_blk_i[`FDCT_BLK*r+3]});

            assign a0 = d0 + d3;
            assign a1 = d1 + d2;
            assign a2 = d1 - d2;
            assign a3 = d0 - d3;

            // Fixed-point rotation, 2217 and 5352 are the scaled cos and sin
            assign p1 = a2 * 2217 + a3 * 5352 + 1812;
            assign p3 = a3 * 2217 - a2 * 5352 + 937;

            assign tmp_nxt[`FDCT_BLK*r+0] = fdct_pkg::tmp_t'((a0 + a1) * 8);
            assign tmp_nxt[`FDCT_BLK*r+1] = fdct_pkg::tmp_t'(p1 >>> 9);
            assign tmp_nxt[`FDCT_BLK*r+2] = fdct_pkg::tmp_t'((a0 - a1) * 8);
            assign tmp_nxt[`FDCT_BLK*r+3] = fdct_pkg::tmp_t'(p3 >>> 9);
        end
    endgenerate

    // ----------------------------------------
    // Pipeline registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid_o <= 1'b0;
        end else begin
            row_valid_o <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            row_tmp_o <= tmp_nxt; // Held until the next start
        end
    end

endmodule

// File: design/fdct_settings.svh
`ifndef FDCT_SETTINGS_SVH
`define FDCT_SETTINGS_SVH

// ----------------------------------------
// Block geometry
// ----------------------------------------
`define FDCT_BLK 4 // Butterfly only exists for 4x4

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define FDCT_PIX_W  8
`define FDCT_TMP_W  14 // Row pass output
`define FDCT_COEF_W 12

// ----------------------------------------
// APB map, byte offsets
// ----------------------------------------
`define FDCT_APB_AW      8
`define FDCT_SRC_BASE    8'h00
`define FDCT_REF_BASE    8'h10
`define FDCT_CTRL_ADDR   8'h20
`define FDCT_STATUS_ADDR 8'h24
`define FDCT_COEF_BASE   8'h40

`endif

// File: src.f
+incdir+design
design/fdct_pkg.sv
design/fdct_row_pass.sv
design/fdct_col_pass.sv
design/fdct_apb_regs.sv
design/fdct_apb_top.sv
bench/fdct_clk_gen.sv
bench/fdct_properties.sv
bench/fdct_tb.sv
